/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - verilog/mips_pkg.sv
  - verilog/instr_fetch.sv
  - verilog/instr_decode.sv
  - verilog/alu_execute.sv
  - verilog/mem_writeback.sv
  - verilog/mips_pipeline.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_mips_pipeline.sv

/* bench/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [DATA_W-1:0] rtype_word(funct_e fn, int rd, int rs, int rt);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic logic [DATA_W-1:0] itype_word(opcode_e op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic void emit(logic [DATA_W-1:0] word);
    prog[prog_len] = word;
    prog_len++;
endfunction

function automatic void seed_registers();
    prog_len = 0;
    for (int n = 1; n < 2**REG_ADDR_W; n++) begin
        emit(itype_word(OP_ADDIU, n, 0, n * 'h0923));   // r15 to r28 come out negative
    end
    emit(itype_word(OP_HALT, 0, 0, 0));
endfunction

function automatic void independent_ops();
    prog_len = 0;
    emit(rtype_word(F_ADDU, 9, 1, 2));
    emit(rtype_word(F_SUBU, 10, 3, 20));
    emit(rtype_word(F_AND, 11, 4, 21));
    emit(rtype_word(F_OR, 12, 5, 22));
    emit(rtype_word(F_XOR, 13, 6, 23));
    emit(rtype_word(F_SLT, 14, 17, 18));      // Both negative
    emit(rtype_word(F_SLT, 29, 18, 17));
    emit(rtype_word(F_SLT, 30, 24, 7));
    emit(itype_word(OP_HALT, 0, 0, 0));
endfunction

function automatic void dependent_chains();
    prog_len = 0;
    emit(rtype_word(F_ADDU, 1, 2, 3));
    emit(rtype_word(F_ADDU, 4, 1, 2));
    emit(rtype_word(F_SUBU, 5, 4, 1));
    emit(rtype_word(F_XOR, 6, 5, 4));
    emit(itype_word(OP_ADDIU, 8, 6, 7));
    emit(itype_word(OP_ADDIU, 8, 8, -3));
    emit(rtype_word(F_OR, 9, 8, 8));          // Newer r8 must win
    emit(rtype_word(F_AND, 10, 9, 6));
    emit(rtype_word(F_SLT, 11, 10, 8));
    emit(itype_word(OP_HALT, 0, 0, 0));
endfunction

function automatic void immediate_forms();
    prog_len = 0;
    emit(itype_word(OP_ADDIU, 12, 0, -1));
    emit(itype_word(OP_ANDI, 13, 12, 'h8001));
    emit(itype_word(OP_ORI, 14, 0, 'hf0f0));
    emit(itype_word(OP_ADDIU, 15, 14, -32768));
    emit(itype_word(OP_ORI, 16, 15, 'h8000));
    emit(rtype_word(F_ADDU, 0, 12, 12));
    emit(itype_word(OP_ORI, 0, 0, 5));
    emit(rtype_word(F_ADDU, 17, 0, 0));
    emit(itype_word(OP_ADDIU, 18, 0, 'h7fff));
    emit(itype_word(OP_HALT, 0, 0, 0));
endfunction

function automatic void store_load();
    prog_len = 0;
    emit(itype_word(OP_ADDIU, 20, 0, 16));
    emit(itype_word(OP_ADDIU, 21, 0, 'h1234));
    emit(itype_word(OP_SW, 21, 20, 4));
    emit(itype_word(OP_LW, 22, 20, 4));
    emit(rtype_word(F_ADDU, 23, 22, 22));     // Load-use
    emit(itype_word(OP_SW, 23, 0, 8));
    emit(itype_word(OP_LW, 24, 0, 8));
    emit(itype_word(OP_SW, 24, 0, 12));
    emit(itype_word(OP_LW, 25, 0, 12));
    emit(rtype_word(F_SUBU, 26, 25, 21));
    emit(itype_word(OP_HALT, 0, 0, 0));
endfunction

function automatic void counter_bump();
    prog_len = 0;
    emit(itype_word(OP_ADDIU, 27, 27, 3));
    emit(itype_word(OP_SW, 27, 0, 40));
    emit(itype_word(OP_LW, 28, 0, 40));
    emit(rtype_word(F_ADDU, 28, 28, 27));
    emit(itype_word(OP_HALT, 0, 0, 0));
endfunction

function automatic void random_mix(int count);
    int kind;
    int rd;
    int rs;
    int rt;
    int imm;
    int slot;
    prog_len = 0;
    for (int k = 0; k < 8; k++) begin
        emit(itype_word(OP_SW, k % 7 + 1, 0, 4 * k));   // Every slot a load may use
    end
    for (int k = 0; k < count; k++) begin
        kind = $urandom_range(0, 10);
        rd   = $urandom_range(1, 7);
        rs   = $urandom_range(1, 7);
        rt   = $urandom_range(1, 7);
        imm  = $urandom_range(0, 'hffff);
        slot = $urandom_range(0, 7);
        case (kind)
            0: emit(rtype_word(F_ADDU, rd, rs, rt));
            1: emit(rtype_word(F_SUBU, rd, rs, rt));
            2: emit(rtype_word(F_AND, rd, rs, rt));
            3: emit(rtype_word(F_OR, rd, rs, rt));
            4: emit(rtype_word(F_XOR, rd, rs, rt));
            5: emit(rtype_word(F_SLT, rd, rs, rt));
            6: emit(itype_word(OP_ADDIU, rt, rs, imm));
            7: emit(itype_word(OP_ANDI, rt, rs, imm));
            8: emit(itype_word(OP_ORI, rt, rs, imm));
            9: emit(itype_word(OP_LW, rt, 0, 4 * slot));
            default: emit(itype_word(OP_SW, rt, 0, 4 * slot));
        endcase
    end
    emit(itype_word(OP_HALT, 0, 0, 0));
endfunction

// Executes the program in order on the model state
function automatic void run_reference();
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] simm;
    logic [DATA_W-1:0] zimm;
    logic [DATA_W-1:0] addr;
    int                rs;
    int                rt;
    int                rd;
    bit                halted;
    halted = 1'b0;
    for (int pc = 0; pc < prog_len && !halted; pc++) begin
        word = prog[pc];
        rs   = word[RS_LSB +: REG_ADDR_W];
        rt   = word[RT_LSB +: REG_ADDR_W];
        rd   = word[RD_LSB +: REG_ADDR_W];
        a    = model_regs[rs];
        b    = model_regs[rt];
        simm = {{(DATA_W-IMM_W){word[IMM_W-1]}}, word[IMM_W-1:0]};
        zimm = {{(DATA_W-IMM_W){1'b0}}, word[IMM_W-1:0]};
        addr = a + simm;
        case (word[OPCODE_LSB +: 6])
            OP_RTYPE: case (word[5:0])
                F_ADDU:  model_regs[rd] = a + b;
                F_SUBU:  model_regs[rd] = a - b;
                F_AND:   model_regs[rd] = a & b;
                F_OR:    model_regs[rd] = a | b;
                F_XOR:   model_regs[rd] = a ^ b;
                F_SLT:   model_regs[rd] = ($signed(a) < $signed(b)) ? 1 : 0;
                default: ;
            endcase
            OP_ADDIU: model_regs[rt] = a + simm;
            OP_ANDI:  model_regs[rt] = a & zimm;
            OP_ORI:   model_regs[rt] = a | zimm;
            OP_LW:    model_regs[rt] = model_dmem[addr[7:2]];
            OP_SW:    model_dmem[addr[7:2]] = b;
            OP_HALT:  halted = 1'b1;
            default:  ;
        endcase
        model_regs[0] = '0;     // r0 is hardwired
    end
endfunction

`endif

/* bench/tb_mips_pipeline.sv */
`timescale 1ns/1ns
module tb_mips_pipeline;
    import mips_pkg::*;

    localparam int SEED           = 33452;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_MARGIN = 60;
    localparam int RANDOM_LEN     = 40;
    localparam int RANDOM_RUNS    = 3;

    logic                   clock = 1'b0;
    logic                   arst_n;
    logic                   run_req;
    logic                   run_ack;
    logic                   imem_we;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    logic [DATA_W-1:0]      imem_data;
    logic [REG_ADDR_W-1:0]  dbg_addr;
    logic [DATA_W-1:0]      dbg_data;

    logic [DATA_W-1:0]      prog [IMEM_DEPTH];
    int                     prog_len;
    logic [DATA_W-1:0]      model_regs [2**REG_ADDR_W];
    logic [DATA_W-1:0]      model_dmem [DMEM_DEPTH];

    string                  test_name;
    logic                   sweep_valid;
    logic [REG_ADDR_W-1:0]  sweep_idx;
    int                     error_count = 0;
    int                     cycle_count = 0;
    int                     cycle_limit = 0;

    `include "tb_programs.svh"

    mips_pipeline mips_pipeline_inst (
        .i_clock(clock), .i_arst_n(arst_n),
        .i_run_req(run_req), .o_run_ack(run_ack),
        .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_data(imem_data),
        .i_dbg_addr(dbg_addr), .o_dbg_data(dbg_data)
    );

    always #4 clock = ~clock;   // 8 ns period

    task automatic fail_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] idx,
                             input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s r%0d expected %h actual %h",
                               name, idx, expected, actual));
        end
    endtask

    task automatic check_ack(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s run_ack expected %b actual %b", name, expected, actual));
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles, test %s did not complete",
                               cycle_count, test_name));
        end
    end

    // One register per cycle while a debug sweep runs
    always @(negedge clock) begin
        if (sweep_valid) begin
            check_reg(test_name, sweep_idx, model_regs[sweep_idx], dbg_data);
        end
    end

    task automatic write_program();
        for (int a = 0; a < prog_len; a++) begin
            @(posedge clock);
            imem_we   <= 1'b1;
            imem_addr <= IMEM_ADDR_W'(a);
            imem_data <= prog[a];
        end
        @(posedge clock);
        imem_we <= 1'b0;
    endtask

    task automatic run_handshake(input string name);
        @(negedge clock);
        check_ack({name, " idle"}, 1'b0, run_ack);
        @(posedge clock);
        run_req <= 1'b1;
        while (run_ack !== 1'b1) @(negedge clock);
        @(posedge clock);
        run_req <= 1'b0;
        @(negedge clock);
        check_ack({name, " held"}, 1'b1, run_ack);     // Still done until the drop is seen
        while (run_ack !== 1'b0) @(negedge clock);
        @(negedge clock);
        check_ack({name, " released"}, 1'b0, run_ack);
    endtask

    // Debug read lags the address by a cycle
    task automatic sweep_registers();
        for (int i = 0; i <= 2**REG_ADDR_W; i++) begin
            @(posedge clock);
            if (i < 2**REG_ADDR_W) dbg_addr <= REG_ADDR_W'(i);
            sweep_valid <= (i > 0);
            sweep_idx   <= REG_ADDR_W'(i - 1);
        end
        @(posedge clock);
        sweep_valid <= 1'b0;
    endtask

    task automatic run_test(input string name);
        cycle_limit += 3 * prog_len + TIMEOUT_MARGIN;
        test_name = name;
        run_reference();
        write_program();
        run_handshake(name);
        sweep_registers();
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n        = 1'b0;
        run_req       = 1'b0;
        imem_we       = 1'b0;
        imem_addr     = '0;
        imem_data     = '0;
        dbg_addr      = '0;
        sweep_valid   = 1'b0;
        sweep_idx     = '0;
        model_regs[0] = '0;
        cycle_limit   = RESET_CYCLES + TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        check_ack("after_reset", 1'b0, run_ack);
        seed_registers();
        run_test("seed_registers");
        independent_ops();
        run_test("independent_ops");
        dependent_chains();
        run_test("dependent_chains");
        immediate_forms();
        run_test("immediate_forms");
        store_load();
        run_test("store_load");
        counter_bump();
        run_test("rerun_first");
        run_test("rerun_second");                   // Reloaded, so fetch restarts at 0
        for (int n = 0; n < RANDOM_RUNS; n++) begin
            random_mix(RANDOM_LEN);
            run_test($sformatf("random_%0d", n));
        end
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_run("Checks failed without stopping the run");
        end
    end

endmodule

/* list.f */
+incdir+bench
verilog/mips_pkg.sv
verilog/instr_fetch.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/mem_writeback.sv
verilog/mips_pipeline.sv
bench/tb_mips_pipeline.sv

/* verilog/alu_execute.sv */
`timescale 1ns/1ns
module alu_execute (
    input  logic                            i_clock,
    input  logic                            i_arst_n,
    input  logic                            i_run_en,
    input  logic                            i_run_clear,
    input  mips_pkg::alu_op_e               i_ex_alu_op,
    input  logic                            i_ex_use_imm,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_rt,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_dest,
    input  logic [mips_pkg::DATA_W-1:0]     i_ex_data_a,
    input  logic [mips_pkg::DATA_W-1:0]     i_ex_data_b,
    input  logic [mips_pkg::DATA_W-1:0]     i_ex_imm,
    input  logic                            i_ex_reg_we,
    input  logic                            i_ex_mem_rd,
    input  logic                            i_ex_mem_wr,
    input  logic                            i_ex_halt,
    input  logic                            i_wb_we,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_addr,
    input  logic [mips_pkg::DATA_W-1:0]     i_wb_data,
    output logic [mips_pkg::DATA_W-1:0]     o_mem_result,
    output logic [mips_pkg::DATA_W-1:0]     o_mem_store_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_mem_dest,
    output logic                            o_mem_reg_we,
    output logic                            o_mem_rd,
    output logic                            o_mem_wr,
    output logic                            o_mem_halt
);
    import mips_pkg::*;

    fwd_sel_e          fwd_a;
    fwd_sel_e          fwd_b;
    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] result;

    // Youngest producer wins, r0 never forwarded
    always_comb begin
        fwd_a = FWD_NONE;
        if (i_ex_rs != '0 && o_mem_reg_we && o_mem_dest == i_ex_rs) begin
            fwd_a = FWD_MEM;
        end else if (i_ex_rs != '0 && i_wb_we && i_wb_addr == i_ex_rs) begin
            fwd_a = FWD_WB;
        end
        fwd_b = FWD_NONE;
        if (i_ex_rt != '0 && o_mem_reg_we && o_mem_dest == i_ex_rt) begin
            fwd_b = FWD_MEM;
        end else if (i_ex_rt != '0 && i_wb_we && i_wb_addr == i_ex_rt) begin
            fwd_b = FWD_WB;
        end
    end

    always_comb begin
        case (fwd_a)
            FWD_MEM: reg_a = o_mem_result;
            FWD_WB:  reg_a = i_wb_data;
            default: reg_a = i_ex_data_a;
        endcase
        case (fwd_b)
            FWD_MEM: reg_b = o_mem_result;
            FWD_WB:  reg_b = i_wb_data;
            default: reg_b = i_ex_data_b;     // Also the store data
        endcase
    end

    assign op_b  = i_ex_use_imm ? i_ex_imm : reg_b;

    always_comb begin
        case (i_ex_alu_op)
            ALU_SUB: result = reg_a - op_b;
            ALU_AND: result = reg_a & op_b;
            ALU_OR:  result = reg_a | op_b;
            ALU_XOR: result = reg_a ^ op_b;
            ALU_SLT: result = {{(DATA_W-1){1'b0}}, $signed(reg_a) < $signed(op_b)};
            default: result = reg_a + op_b;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_reg_we <= 1'b0;
            o_mem_rd     <= 1'b0;
            o_mem_wr     <= 1'b0;
            o_mem_halt   <= 1'b0;
        end else if (i_run_clear) begin
            o_mem_reg_we <= 1'b0;
            o_mem_rd     <= 1'b0;
            o_mem_wr     <= 1'b0;
            o_mem_halt   <= 1'b0;
        end else if (i_run_en) begin
            o_mem_reg_we <= i_ex_reg_we;
            o_mem_rd     <= i_ex_mem_rd;
            o_mem_wr     <= i_ex_mem_wr;
            o_mem_halt   <= i_ex_halt;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run_en) begin
            o_mem_result     <= result;
            o_mem_store_data <= reg_b;
            o_mem_dest       <= i_ex_dest;
        end
    end

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/1ns
module instr_decode (
    input  logic                            i_clock,
    input  logic                            i_arst_n,
    input  logic                            i_run_en,
    input  logic                            i_run_clear,
    input  logic [mips_pkg::DATA_W-1:0]     i_instr,
    input  logic                            i_wb_we,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_addr,
    input  logic [mips_pkg::DATA_W-1:0]     i_wb_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dbg_addr,
    output logic [mips_pkg::DATA_W-1:0]     o_dbg_data,
    output logic                            o_stall,
    output mips_pkg::alu_op_e               o_ex_alu_op,
    output logic                            o_ex_use_imm,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_dest,
    output logic [mips_pkg::DATA_W-1:0]     o_ex_data_a,
    output logic [mips_pkg::DATA_W-1:0]     o_ex_data_b,
    output logic [mips_pkg::DATA_W-1:0]     o_ex_imm,
    output logic                            o_ex_reg_we,
    output logic                            o_ex_mem_rd,
    output logic                            o_ex_mem_wr,
    output logic                            o_ex_halt
);
    import mips_pkg::*;

    logic [DATA_W-1:0]     regs [2**REG_ADDR_W];
    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] dest;
    logic [DATA_W-1:0]     imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  sign_ext;
    logic                  reg_we;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  halt;

    assign opcode = opcode_e'(i_instr[OPCODE_LSB +: 6]);
    assign funct  = funct_e'(i_instr[5:0]);
    assign rs     = i_instr[RS_LSB +: REG_ADDR_W];
    assign rt     = i_instr[RT_LSB +: REG_ADDR_W];
    assign imm    = sign_ext ? {{(DATA_W-IMM_W){i_instr[IMM_W-1]}}, i_instr[IMM_W-1:0]}
                             : {{(DATA_W-IMM_W){1'b0}}, i_instr[IMM_W-1:0]};

    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b1;
        sign_ext = 1'b1;
        dest     = rt;
        reg_we   = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        halt     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                use_imm = 1'b0;
                dest    = i_instr[RD_LSB +: REG_ADDR_W];
                reg_we  = 1'b1;
                case (funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_SLT:   alu_op = ALU_SLT;
                    default: reg_we = 1'b0;     // Unknown funct, nop
                endcase
            end
            OP_ADDIU: reg_we = 1'b1;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                sign_ext = 1'b0;
                reg_we   = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                sign_ext = 1'b0;
                reg_we   = 1'b1;
            end
            OP_LW: begin
                reg_we = 1'b1;
                mem_rd = 1'b1;
            end
            OP_SW:   mem_wr = 1'b1;
            OP_HALT: halt   = 1'b1;
            default: ;
        endcase
    end

    function automatic logic [DATA_W-1:0] read_bank(input logic [REG_ADDR_W-1:0] addr);
        logic [DATA_W-1:0] value;
        if (addr == '0) value = '0;
        else if (i_wb_we && i_wb_addr == addr) value = i_wb_data;  // Write bypass
        else value = regs[addr];
        return value;
    endfunction

    always_ff @(posedge i_clock) begin
        if (i_wb_we && i_wb_addr != '0) begin
            regs[i_wb_addr] <= i_wb_data;
        end
        o_dbg_data <= (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];
    end

    assign o_stall = o_ex_mem_rd && (o_ex_rt == rs || o_ex_rt == rt);   // Load-use

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_reg_we <= 1'b0;
            o_ex_mem_rd <= 1'b0;
            o_ex_mem_wr <= 1'b0;
            o_ex_halt   <= 1'b0;
        end else if (i_run_clear || (i_run_en && o_stall)) begin
            o_ex_reg_we <= 1'b0;            // Bubble
            o_ex_mem_rd <= 1'b0;
            o_ex_mem_wr <= 1'b0;
            o_ex_halt   <= 1'b0;
        end else if (i_run_en) begin
            o_ex_reg_we <= reg_we;
            o_ex_mem_rd <= mem_rd;
            o_ex_mem_wr <= mem_wr;
            o_ex_halt   <= halt;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run_en) begin
            o_ex_alu_op  <= alu_op;
            o_ex_use_imm <= use_imm;
            o_ex_rs      <= rs;
            o_ex_rt      <= rt;
            o_ex_dest    <= dest;
            o_ex_data_a  <= read_bank(rs);
            o_ex_data_b  <= read_bank(rt);
            o_ex_imm     <= imm;
        end
    end

endmodule

/* verilog/instr_fetch.sv */
`timescale 1ns/1ns
module instr_fetch (
    input  logic                             i_clock,
    input  logic                             i_arst_n,
    input  logic                             i_run_en,
    input  logic                             i_run_clear,
    input  logic                             i_stall,
    input  logic                             i_imem_we,
    input  logic [mips_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  logic [mips_pkg::DATA_W-1:0]      i_imem_data,
    output logic [mips_pkg::DATA_W-1:0]      o_instr
);
    import mips_pkg::*;

    logic [DATA_W-1:0]      imem [IMEM_DEPTH];
    logic [IMEM_ADDR_W-1:0] pc;
    logic                   advance;

    assign advance = i_run_en && !i_stall;

    always_ff @(posedge i_clock) begin
        if (i_imem_we && !i_run_en && !i_run_clear) begin   // Host load while parked
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // Word PC and IF/ID register
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= '0;
            o_instr <= '0;
        end else if (i_run_clear) begin
            pc      <= '0;
            o_instr <= '0;                  // Zero word is a no-op
        end else if (advance) begin
            pc      <= pc + 1'b1;
            o_instr <= imem[pc];
        end
    end

    // Program memory must stay still while instructions are in flight
    assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_imem_we |-> !i_run_en && !i_run_clear)
        else $error("instruction memory written while the core runs");

endmodule

/* verilog/mem_writeback.sv */
`timescale 1ns/1ns
module mem_writeback (
    input  logic                            i_clock,
    input  logic                            i_arst_n,
    input  logic                            i_run_en,
    input  logic                            i_run_clear,
    input  logic [mips_pkg::DATA_W-1:0]     i_mem_result,
    input  logic [mips_pkg::DATA_W-1:0]     i_mem_store_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_mem_dest,
    input  logic                            i_mem_reg_we,
    input  logic                            i_mem_rd,
    input  logic                            i_mem_wr,
    input  logic                            i_mem_halt,
    output logic                            o_wb_we,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_wb_addr,
    output logic [mips_pkg::DATA_W-1:0]     o_wb_data,
    output logic                            o_wb_halt
);
    import mips_pkg::*;

    logic [DATA_W-1:0]      dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] dmem_idx;
    logic                   wb_is_load;
    logic [DATA_W-1:0]      wb_load_data;
    logic [DATA_W-1:0]      wb_result;

    assign dmem_idx = i_mem_result[DMEM_ADDR_W+1:2];    // Word address

    always_ff @(posedge i_clock) begin
        if (i_run_en && i_mem_wr) begin
            dmem[dmem_idx] <= i_mem_store_data;
        end
        if (i_run_en) begin
            wb_load_data <= dmem[dmem_idx];
            wb_result    <= i_mem_result;
            o_wb_addr    <= i_mem_dest;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_we    <= 1'b0;
            wb_is_load <= 1'b0;
            o_wb_halt  <= 1'b0;
        end else if (i_run_clear) begin
            o_wb_we    <= 1'b0;
            wb_is_load <= 1'b0;
            o_wb_halt  <= 1'b0;
        end else if (i_run_en) begin
            o_wb_we    <= i_mem_reg_we;
            wb_is_load <= i_mem_rd;
            o_wb_halt  <= i_mem_halt;
        end
    end

    assign o_wb_data = wb_is_load ? wb_load_data : wb_result;

    // Decode never issues a slot that both reads and writes memory
    assert property (@(posedge i_clock) disable iff (!i_arst_n) !(i_mem_rd && i_mem_wr))
        else $error("load and store in the same MEM slot");

endmodule

/* verilog/mips_pipeline.sv */
`timescale 1ns/1ns
module mips_pipeline (
    input  logic                             i_clock,
    input  logic                             i_arst_n,
    input  logic                             i_run_req,
    output logic                             o_run_ack,
    input  logic                             i_imem_we,
    input  logic [mips_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  logic [mips_pkg::DATA_W-1:0]      i_imem_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0]  i_dbg_addr,
    output logic [mips_pkg::DATA_W-1:0]      o_dbg_data
);
    import mips_pkg::*;

    run_state_e            run_state;
    logic                  run_en;
    logic                  run_clear;
    logic                  stall;
    logic [DATA_W-1:0]     instr;
    alu_op_e               ex_alu_op;
    logic                  ex_use_imm;
    logic [REG_ADDR_W-1:0] ex_rs;
    logic [REG_ADDR_W-1:0] ex_rt;
    logic [REG_ADDR_W-1:0] ex_dest;
    logic [DATA_W-1:0]     ex_data_a;
    logic [DATA_W-1:0]     ex_data_b;
    logic [DATA_W-1:0]     ex_imm;
    logic                  ex_reg_we;
    logic                  ex_mem_rd;
    logic                  ex_mem_wr;
    logic                  ex_halt;
    logic [DATA_W-1:0]     mem_result;
    logic [DATA_W-1:0]     mem_store_data;
    logic [REG_ADDR_W-1:0] mem_dest;
    logic                  mem_reg_we;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  mem_halt;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;
    logic                  wb_halt;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            run_state <= RUN_IDLE;
            o_run_ack <= 1'b0;
        end else begin
            o_run_ack <= (run_state == RUN_DONE) && i_run_req;
            case (run_state)
                RUN_IDLE: if (i_run_req) run_state <= RUN_BUSY;
                RUN_BUSY: if (wb_halt) run_state <= RUN_DONE;
                RUN_DONE: if (!i_run_req) run_state <= RUN_IDLE;
                default:  run_state <= RUN_IDLE;
            endcase
        end
    end

    assign run_clear = (run_state == RUN_IDLE) && i_run_req;
    assign run_en    = (run_state == RUN_BUSY) && !wb_halt;   // Freeze once HALT retires

    instr_fetch instr_fetch_inst (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_run_en(run_en), .i_run_clear(run_clear), .i_stall(stall),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_instr(instr)
    );

    instr_decode instr_decode_inst (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_run_en(run_en), .i_run_clear(run_clear), .i_instr(instr),
        .i_wb_we(wb_we), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
        .i_dbg_addr(i_dbg_addr), .o_dbg_data(o_dbg_data), .o_stall(stall),
        .o_ex_alu_op(ex_alu_op), .o_ex_use_imm(ex_use_imm),
        .o_ex_rs(ex_rs), .o_ex_rt(ex_rt), .o_ex_dest(ex_dest),
        .o_ex_data_a(ex_data_a), .o_ex_data_b(ex_data_b), .o_ex_imm(ex_imm),
        .o_ex_reg_we(ex_reg_we), .o_ex_mem_rd(ex_mem_rd), .o_ex_mem_wr(ex_mem_wr),
        .o_ex_halt(ex_halt)
    );

    alu_execute alu_execute_inst (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_run_en(run_en), .i_run_clear(run_clear),
        .i_ex_alu_op(ex_alu_op), .i_ex_use_imm(ex_use_imm),
        .i_ex_rs(ex_rs), .i_ex_rt(ex_rt), .i_ex_dest(ex_dest),
        .i_ex_data_a(ex_data_a), .i_ex_data_b(ex_data_b), .i_ex_imm(ex_imm),
        .i_ex_reg_we(ex_reg_we), .i_ex_mem_rd(ex_mem_rd), .i_ex_mem_wr(ex_mem_wr),
        .i_ex_halt(ex_halt),
        .i_wb_we(wb_we), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
        .o_mem_result(mem_result), .o_mem_store_data(mem_store_data),
        .o_mem_dest(mem_dest), .o_mem_reg_we(mem_reg_we),
        .o_mem_rd(mem_rd), .o_mem_wr(mem_wr), .o_mem_halt(mem_halt)
    );

    mem_writeback mem_writeback_inst (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_run_en(run_en), .i_run_clear(run_clear),
        .i_mem_result(mem_result), .i_mem_store_data(mem_store_data),
        .i_mem_dest(mem_dest), .i_mem_reg_we(mem_reg_we),
        .i_mem_rd(mem_rd), .i_mem_wr(mem_wr), .i_mem_halt(mem_halt),
        .o_wb_we(wb_we), .o_wb_addr(wb_addr), .o_wb_data(wb_data), .o_wb_halt(wb_halt)
    );

    // Acknowledge only follows a retired HALT
    assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(o_run_ack) |-> $past(wb_halt, 2))
        else $error("run acknowledge without a halt at write-back");

endmodule

/* verilog/mips_pkg.sv */
package mips_pkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;

    localparam int IMEM_DEPTH  = 64;
    localparam int DMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;
    localparam int DMEM_ADDR_W = 6;   // Indexed by result bits 7:2

    // Instruction word fields
    localparam int OPCODE_LSB  = 26;
    localparam int RS_LSB      = 21;
    localparam int RT_LSB      = 16;
    localparam int RD_LSB      = 11;
    localparam int IMM_W       = 16;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_BUSY,
        RUN_DONE
    } run_state_e;

endpackage
